// ==== verification/vec_testdata.txt ====
// record: header {n_in[47:40], n_out[39:32], instr[31:0]}, then n_in stream phits,
// then n_out expected output phits; a header with top byte ff ends the list
0000_0000_1000_0100  // set vl 4
0000_0400_3000_0000  // stream load into 0..3
1111_2222_3333_4444 5555_6666_7777_8888 9999_aaaa_bbbb_cccc dddd_eeee_ffff_0123
0000_0004_5000_0000  // store 0..3, same phits back
1111_2222_3333_4444 5555_6666_7777_8888 9999_aaaa_bbbb_cccc dddd_eeee_ffff_0123
0000_0000_212f_bbc0  // splat beef into 4..7
0000_0004_5004_0000  // store 4..7
beef_beef_beef_beef beef_beef_beef_beef beef_beef_beef_beef beef_beef_beef_beef
0000_0400_3200_0000  // load a into 8..11
0001_0002_0003_0004 0010_0020_0030_0040 0100_0200_0300_0400 1000_2000_ffff_8000
0000_0400_3300_0000  // load b into 12..15
0005_0006_0007_0008 0002_0002_0002_0002 0100_0010_0001_0000 0010_0008_0003_0002
0000_0000_2400_00c0  // splat 3 into 16..19
0000_0000_4408_3000  // mac 16..19 += a * b
0000_0004_5010_0000  // store 16..19, lanes wrap at 16 bits
0008_000f_0018_0023 0023_0043_0063_0083 0003_2003_0303_0003 0003_0003_0000_0003
0000_0000_1000_00c0  // set vl 3
0000_0003_5008_0000  // store 8..10
0001_0002_0003_0004 0010_0020_0030_0040 0100_0200_0300_0400
0000_0000_1000_0400  // set vl 16
0000_0010_5000_0000  // store 0..15
1111_2222_3333_4444 5555_6666_7777_8888 9999_aaaa_bbbb_cccc dddd_eeee_ffff_0123
beef_beef_beef_beef beef_beef_beef_beef beef_beef_beef_beef beef_beef_beef_beef
0001_0002_0003_0004 0010_0020_0030_0040 0100_0200_0300_0400 1000_2000_ffff_8000
0005_0006_0007_0008 0002_0002_0002_0002 0100_0010_0001_0000 0010_0008_0003_0002
ffff_ffff_ffff_ffff  // end of records

// ==== tb.f ====
hw/vec_pkg.sv
hw/vec_decoder.sv
hw/addr_walker.sv
hw/vec_regfile.sv
hw/lane_mac.sv
hw/writeback_result.sv
hw/vec_datapath.sv
verification/vec_datapath_assert.sv
verification/tb_vec_datapath.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_vec_datapath
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# shows the simulation output and fails unless the pass line is in it
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/tb_vec_datapath.sv ====
module tb_vec_datapath;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    MAX_WORDS = 256;
    localparam string DATA_FILE = "verification/vec_testdata.txt";

    logic            clk;
    logic            i_arst_n;
    logic            i_instr_valid;
    vec_pkg::instr_u i_instr;
    logic            i_stream_valid;
    vec_pkg::phit_t  i_stream_data;
    logic            o_busy;
    logic            o_stream_valid;
    vec_pkg::phit_t  o_stream_data;

    logic [63:0] tdata [MAX_WORDS];  // header, stream phits, expected phits
    int          seed = 18;
    int          cycles = 0;
    int          limit = 1000000;    // replaced once the data file is read
    int          mismatches = 0;
    int          other_errors = 0;
    int          out_seen = 0;

    vec_datapath u_dut (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .i_stream_valid (i_stream_valid),
        .i_stream_data  (i_stream_data),
        .o_busy         (o_busy),
        .o_stream_valid (o_stream_valid),
        .o_stream_data  (o_stream_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_and_finish();
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // 16 reset cycles, then per record 2*vl + stream phits + 10
    function automatic int cycle_limit();
        int              idx;
        int              vl;
        int              total;
        vec_pkg::instr_u ins;
        idx   = 0;
        vl    = 1;
        total = 16;
        while (idx < MAX_WORDS && tdata[idx][63:56] != 8'hff) begin
            ins = tdata[idx][31:0];
            if (ins.i.op == vec_pkg::OP_SETVL) begin
                vl = (ins.i.imm[4:0] == 5'd0) ? 1 : int'(ins.i.imm[4:0]);
            end
            total += 2 * vl + int'(tdata[idx][47:40]) + 10;
            idx   += 1 + int'(tdata[idx][47:40]) + int'(tdata[idx][39:32]);
        end
        return total;
    endfunction

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            other_errors++;
            $display("timeout: the run went past its limit of %0d cycles", limit);
            report_and_finish();
        end
    end

    // every output word is counted, and none may come while idle
    always @(negedge clk) begin
        if (i_arst_n && o_stream_valid) begin
            out_seen++;
            if (!o_busy) begin
                other_errors++;
                $display("%0t: output word sent while o_busy is low", $time);
            end
        end
    end

    task automatic wait_idle();
        while (o_busy) begin
            @(negedge clk);
        end
    endtask

    task automatic send_phit(input logic [63:0] phit);
        int gap;
        gap = $unsigned($random(seed)) % 3;  // 0 to 2 idle cycles
        repeat (gap) @(negedge clk);
        i_stream_valid = 1'b1;
        i_stream_data  = phit;
        @(negedge clk);
        i_stream_valid = 1'b0;
    endtask

    // called on the falling edge after the store was accepted
    task automatic check_store(input int base, input int n_out);
        int lat;
        int k;
        lat = 1;
        while (!o_stream_valid) begin
            @(negedge clk);
            lat++;
        end
        if (lat != 4) begin
            other_errors++;
            $display("%0t: first output word after %0d rising edges, expected 4", $time, lat);
        end
        for (k = 0; k < n_out; k++) begin
            if (k > 0) begin
                @(negedge clk);
            end
            if (!o_stream_valid) begin
                other_errors++;
                $display("%0t: output word %0d is missing, the stream has a gap", $time, k);
            end else if (o_stream_data !== tdata[base + k]) begin
                mismatches++;
                $display("MISMATCH %0t: output word %0d is %h, expected %h",
                         $time, k, o_stream_data, tdata[base + k]);
            end
        end
        @(negedge clk);
        if (o_stream_valid) begin
            other_errors++;
            $display("%0t: more output words than the vector length", $time);
        end
    endtask

    initial begin
        int          idx;
        int          n_in;
        int          n_out;
        int          p;
        int          exp_total;
        logic [63:0] hdr;
        i_arst_n       = 1'b0;
        i_instr_valid  = 1'b0;
        i_instr        = '0;
        i_stream_valid = 1'b0;
        i_stream_data  = '0;
        $readmemh(DATA_FILE, tdata);
        limit = cycle_limit();
        repeat (16) @(negedge clk);
        i_arst_n = 1'b1;

        repeat (3) begin  // quiet until the first instruction
            @(negedge clk);
            if (o_busy || o_stream_valid) begin
                other_errors++;
                $display("%0t: o_busy or o_stream_valid high before any instruction", $time);
            end
        end

        idx       = 0;
        exp_total = 0;
        while (idx < MAX_WORDS && tdata[idx][63:56] != 8'hff) begin
            hdr   = tdata[idx];
            n_in  = int'(hdr[47:40]);
            n_out = int'(hdr[39:32]);
            idx++;
            wait_idle();
            i_instr_valid = 1'b1;
            i_instr       = hdr[31:0];
            @(negedge clk);
            i_instr_valid = 1'b0;
            for (p = 0; p < n_in; p++) begin
                send_phit(tdata[idx]);
                idx++;
            end
            if (n_out > 0) begin
                check_store(idx, n_out);
                idx       += n_out;
                exp_total += n_out;
            end
        end

        wait_idle();
        repeat (4) @(negedge clk);
        if (out_seen != exp_total) begin
            other_errors++;
            $display("saw %0d output words in all, expected %0d", out_seen, exp_total);
        end
        report_and_finish();
    end

endmodule

// ==== verification/vec_datapath_assert.sv ====
module vec_datapath_assert (
    input logic clk,
    input logic i_arst_n,
    input logic i_instr_valid,
    input logic o_busy,
    input logic o_stream_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // outputs stay quiet while reset is held
    reset_quiet: assert property (@(posedge clk) !i_arst_n |-> !o_busy && !o_stream_valid)
        else $error("o_busy or o_stream_valid high during reset");

    stream_in_busy: assert property (
        @(posedge clk) disable iff (!i_arst_n) o_stream_valid |-> o_busy
    ) else $error("o_stream_valid high while o_busy is low");

    // sender has to hold off until busy falls
    no_instr_when_busy: assert property (
        @(posedge clk) disable iff (!i_arst_n) i_instr_valid |-> !o_busy
    ) else $error("instruction strobe while o_busy is high");

endmodule

bind vec_datapath vec_datapath_assert u_assert (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_instr_valid  (i_instr_valid),
    .o_busy         (o_busy),
    .o_stream_valid (o_stream_valid)
);

// ==== hw/vec_datapath.sv ====
module vec_datapath #(
    parameter int NUM_ENTRIES = 64,
    parameter int MAX_VL      = 16
) (
    input  logic            clk,
    input  logic            i_arst_n,
    input  logic            i_instr_valid,
    input  vec_pkg::instr_u i_instr,
    input  logic            i_stream_valid,
    input  vec_pkg::phit_t  i_stream_data,
    output logic            o_busy,
    output logic            o_stream_valid,
    output vec_pkg::phit_t  o_stream_data
);

    vec_pkg::cmd_t              cmd;
    vec_pkg::rd_req_t           rd_req;
    vec_pkg::phit_t             rd_vd;
    vec_pkg::phit_t             rd_vs1;
    vec_pkg::phit_t             rd_vs2;
    logic                       result_valid;
    vec_pkg::opcode_e           result_op;
    logic [vec_pkg::ADDR_W-1:0] result_addr;
    vec_pkg::phit_t             result;
    vec_pkg::wr_req_t           wr;
    logic                       drain_done;

    vec_decoder u_decoder (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .i_busy        (o_busy),
        .o_cmd         (cmd)
    );

    addr_walker #(.MAX_VL(MAX_VL)) u_walker (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_cmd          (cmd),
        .i_stream_valid (i_stream_valid),
        .i_drain_done   (drain_done),
        .o_rd_req       (rd_req),
        .o_busy         (o_busy)
    );

    vec_regfile #(.NUM_ENTRIES(NUM_ENTRIES)) u_regfile (
        .clk      (clk),
        .i_rd_req (rd_req),
        .i_wr     (wr),
        .o_rd_vd  (rd_vd),
        .o_rd_vs1 (rd_vs1),
        .o_rd_vs2 (rd_vs2)
    );

    // imm is held in the decoder for the whole walk
    lane_mac u_mac (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_req          (rd_req),
        .i_rd_vd        (rd_vd),
        .i_rd_vs1       (rd_vs1),
        .i_rd_vs2       (rd_vs2),
        .i_imm          (cmd.imm),
        .i_stream_data  (i_stream_data),
        .o_result_valid (result_valid),
        .o_result_op    (result_op),
        .o_result_addr  (result_addr),
        .o_result       (result)
    );

    writeback_result u_writeback (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_result_valid (result_valid),
        .i_result_op    (result_op),
        .i_result_addr  (result_addr),
        .i_result       (result),
        .o_wr           (wr),
        .o_stream_valid (o_stream_valid),
        .o_stream_data  (o_stream_data),
        .o_drain_done   (drain_done)
    );

endmodule

// ==== hw/writeback_result.sv ====
module writeback_result (
    input  logic                       clk,
    input  logic                       i_arst_n,
    input  logic                       i_result_valid,
    input  vec_pkg::opcode_e           i_result_op,
    input  logic [vec_pkg::ADDR_W-1:0] i_result_addr,
    input  vec_pkg::phit_t             i_result,
    output vec_pkg::wr_req_t           o_wr,
    output logic                       o_stream_valid,
    output vec_pkg::phit_t             o_stream_data,
    output logic                       o_drain_done
);

    logic is_store;

    assign is_store = (i_result_op == vec_pkg::OP_SSTORE);

    // everything but a store goes back into the register file
    always_comb begin
        o_wr.valid = i_result_valid && !is_store;
        o_wr.addr  = i_result_addr;
        o_wr.data  = i_result;
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_stream_valid <= 1'b0;
        end else begin
            o_stream_valid <= i_result_valid && is_store;
        end
    end

    always_ff @(posedge clk) begin
        if (i_result_valid && is_store) begin
            o_stream_data <= i_result;
        end
    end

    // one pulse per entry leaving, the walker counts them down
    assign o_drain_done = o_wr.valid || o_stream_valid;

endmodule

// ==== hw/lane_mac.sv ====
module lane_mac (
    input  logic                       clk,
    input  logic                       i_arst_n,
    input  vec_pkg::rd_req_t           i_req,
    input  vec_pkg::phit_t             i_rd_vd,
    input  vec_pkg::phit_t             i_rd_vs1,
    input  vec_pkg::phit_t             i_rd_vs2,
    input  logic [vec_pkg::LANE_W-1:0] i_imm,
    input  vec_pkg::phit_t             i_stream_data,
    output logic                       o_result_valid,
    output vec_pkg::opcode_e           o_result_op,
    output logic [vec_pkg::ADDR_W-1:0] o_result_addr,
    output vec_pkg::phit_t             o_result
);

    logic                       req_valid_q;
    vec_pkg::opcode_e           req_op_q;
    logic [vec_pkg::ADDR_W-1:0] req_addr_q;
    vec_pkg::phit_t             stream_q;
    vec_pkg::phit_t             result_d;

    // request stage lines up with the register file read
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            req_valid_q    <= 1'b0;
            o_result_valid <= 1'b0;
        end else begin
            req_valid_q    <= i_req.valid;
            o_result_valid <= req_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        req_op_q   <= i_req.op;
        req_addr_q <= i_req.wr_addr;
        if (i_req.valid) begin
            stream_q <= i_stream_data;  // phit that came with this request
        end
    end

    always_comb begin
        for (int l = 0; l < vec_pkg::NUM_LANES; l++) begin
            case (req_op_q)
                vec_pkg::OP_MAC:   result_d[l] = i_rd_vd[l] + i_rd_vs1[l] * i_rd_vs2[l];
                vec_pkg::OP_SPLAT: result_d[l] = i_imm;
                vec_pkg::OP_SLOAD: result_d[l] = stream_q[l];
                default:           result_d[l] = i_rd_vs1[l];  // store passes vs1
            endcase
        end
    end

    always_ff @(posedge clk) begin
        o_result_op   <= req_op_q;
        o_result_addr <= req_addr_q;
        o_result      <= result_d;  // mac wraps at 16 bits
    end

endmodule

// ==== hw/vec_regfile.sv ====
module vec_regfile #(
    parameter int NUM_ENTRIES = 64
) (
    input  logic             clk,
    input  vec_pkg::rd_req_t i_rd_req,
    input  vec_pkg::wr_req_t i_wr,
    output vec_pkg::phit_t   o_rd_vd,
    output vec_pkg::phit_t   o_rd_vs1,
    output vec_pkg::phit_t   o_rd_vs2
);

    vec_pkg::phit_t mem [NUM_ENTRIES];

    always_ff @(posedge clk) begin
        if (i_wr.valid) begin
            mem[i_wr.addr] <= i_wr.data;
        end
    end

    // three registered read ports, data one cycle after the request
    always_ff @(posedge clk) begin
        if (i_rd_req.valid) begin
            o_rd_vd  <= mem[i_rd_req.rd_vd];   // accumulator for mac
            o_rd_vs1 <= mem[i_rd_req.rd_vs1];
            o_rd_vs2 <= mem[i_rd_req.rd_vs2];
        end
    end

endmodule

// ==== hw/addr_walker.sv ====
module addr_walker #(
    parameter int MAX_VL = 16
) (
    input  logic             clk,
    input  logic             i_arst_n,
    input  vec_pkg::cmd_t    i_cmd,
    input  logic             i_stream_valid,
    input  logic             i_drain_done,
    output vec_pkg::rd_req_t o_rd_req,
    output logic             o_busy
);

    logic                       set_vl;
    logic                       start;
    logic                       fire;
    logic                       last_issue;
    logic                       walk_q;
    logic                       busy_q;
    logic [vec_pkg::VL_W-1:0]   vl_q;
    logic [vec_pkg::VL_W-1:0]   vl_req;
    logic [vec_pkg::VL_W-1:0]   idx_q;    // entries issued
    logic [vec_pkg::VL_W-1:0]   ret_q;    // entries retired
    logic [vec_pkg::VL_W-1:0]   idx;
    logic [vec_pkg::ADDR_W-1:0] offs;
    vec_pkg::opcode_e           op_q;
    vec_pkg::opcode_e           op;
    logic [vec_pkg::ADDR_W-1:0] vd_q;
    logic [vec_pkg::ADDR_W-1:0] vs1_q;
    logic [vec_pkg::ADDR_W-1:0] vs2_q;
    logic [vec_pkg::ADDR_W-1:0] vd;
    logic [vec_pkg::ADDR_W-1:0] vs1;
    logic [vec_pkg::ADDR_W-1:0] vs2;

    assign set_vl = i_cmd.valid && (i_cmd.op == vec_pkg::OP_SETVL);
    assign start  = i_cmd.valid && !set_vl;

    // the first entry goes out straight from the command
    assign op   = start ? i_cmd.op  : op_q;
    assign vd   = start ? i_cmd.vd  : vd_q;
    assign vs1  = start ? i_cmd.vs1 : vs1_q;
    assign vs2  = start ? i_cmd.vs2 : vs2_q;
    assign idx  = start ? '0 : idx_q;
    assign offs = vec_pkg::ADDR_W'(idx);

    // stream loads step only on an incoming phit
    assign fire       = (start || walk_q) && (op != vec_pkg::OP_SLOAD || i_stream_valid);
    assign last_issue = (idx + 1'b1) == vl_q;

    always_comb begin
        vl_req = i_cmd.imm[vec_pkg::VL_W-1:0];
        if (vl_req == '0) begin
            vl_req = 1;
        end else if (int'(vl_req) > MAX_VL) begin
            vl_req = vec_pkg::VL_W'(MAX_VL);  // clamp to what the pipeline supports
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            vl_q   <= 1;
            walk_q <= 1'b0;
            busy_q <= 1'b0;
            idx_q  <= '0;
            ret_q  <= '0;
        end else begin
            if (set_vl) begin
                vl_q <= vl_req;
            end
            if (start) begin
                busy_q <= 1'b1;
            end
            if (fire) begin
                idx_q  <= idx + 1'b1;
                walk_q <= !last_issue;
            end else if (start) begin
                idx_q  <= '0;
                walk_q <= 1'b1;  // waiting for the first phit
            end
            if (i_drain_done) begin
                if (ret_q + 1'b1 == vl_q) begin
                    busy_q <= 1'b0;
                    ret_q  <= '0;
                end else begin
                    ret_q <= ret_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op_q  <= i_cmd.op;
            vd_q  <= i_cmd.vd;
            vs1_q <= i_cmd.vs1;
            vs2_q <= i_cmd.vs2;
        end
    end

    always_comb begin
        o_rd_req.valid   = fire;
        o_rd_req.op      = op;
        o_rd_req.rd_vd   = vd + offs;
        o_rd_req.rd_vs1  = vs1 + offs;
        o_rd_req.rd_vs2  = vs2 + offs;
        o_rd_req.wr_addr = vd + offs;
    end

    // held high from the command until the last entry retires
    assign o_busy = busy_q || start;

endmodule

// ==== hw/vec_decoder.sv ====
module vec_decoder (
    input  logic            clk,
    input  logic            i_arst_n,
    input  logic            i_instr_valid,
    input  vec_pkg::instr_u i_instr,
    input  logic            i_busy,
    output vec_pkg::cmd_t   o_cmd
);

    logic                          legal;
    logic                          accept;
    logic                          valid_q;
    vec_pkg::opcode_e              op_q;
    logic [vec_pkg::ADDR_W-1:0]    vd_q;
    logic [vec_pkg::ADDR_W-1:0]    vs1_q;
    logic [vec_pkg::ADDR_W-1:0]    vs2_q;
    logic [vec_pkg::LANE_W-1:0]    imm_q;

    always_comb begin
        case (i_instr.r.op)
            vec_pkg::OP_SETVL,
            vec_pkg::OP_SPLAT,
            vec_pkg::OP_SLOAD,
            vec_pkg::OP_MAC,
            vec_pkg::OP_SSTORE: legal = 1'b1;
            default:            legal = 1'b0;  // unknown opcode, dropped
        endcase
    end

    assign accept = i_instr_valid && !i_busy && legal;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;  // single-cycle command strobe
        end
    end

    // fields stay put until the next accepted instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q  <= i_instr.r.op;
            vd_q  <= i_instr.r.vd;
            vs1_q <= i_instr.r.vs1;
            vs2_q <= i_instr.r.vs2;
            imm_q <= i_instr.i.imm;  // same word, immediate view
        end
    end

    always_comb begin
        o_cmd.valid = valid_q;
        o_cmd.op    = op_q;
        o_cmd.vd    = vd_q;
        o_cmd.vs1   = vs1_q;
        o_cmd.vs2   = vs2_q;
        o_cmd.imm   = imm_q;
    end

endmodule

// ==== hw/vec_pkg.sv ====
package vec_pkg;

    localparam int PHIT_W    = 64;
    localparam int NUM_LANES = 4;
    localparam int LANE_W    = PHIT_W / NUM_LANES;  // 16-bit integer lanes
    localparam int ADDR_W    = 6;                    // register file entry address
    localparam int VL_W      = 5;                    // holds 1..16
    localparam int INSTR_W   = 32;

    typedef enum logic [3:0] {
        OP_SETVL  = 4'h1,
        OP_SPLAT  = 4'h2,
        OP_SLOAD  = 4'h3,
        OP_MAC    = 4'h4,
        OP_SSTORE = 4'h5
    } opcode_e;

    typedef logic [NUM_LANES-1:0][LANE_W-1:0] phit_t;

    // register form: three entry addresses
    typedef struct packed {
        opcode_e                        op;
        logic [ADDR_W-1:0]              vd;
        logic [ADDR_W-1:0]              vs1;
        logic [ADDR_W-1:0]              vs2;
        logic [INSTR_W-4-3*ADDR_W-1:0]  rsvd;
    } instr_reg_t;

    // immediate form, used by splat and set vector length
    typedef struct packed {
        opcode_e                           op;
        logic [ADDR_W-1:0]                 vd;
        logic [LANE_W-1:0]                 imm;
        logic [INSTR_W-4-ADDR_W-LANE_W-1:0] rsvd;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_u;

    typedef struct packed {
        logic              valid;
        opcode_e           op;
        logic [ADDR_W-1:0] vd;
        logic [ADDR_W-1:0] vs1;
        logic [ADDR_W-1:0] vs2;
        logic [LANE_W-1:0] imm;
    } cmd_t;

    typedef struct packed {
        logic              valid;
        opcode_e           op;
        logic [ADDR_W-1:0] rd_vd;
        logic [ADDR_W-1:0] rd_vs1;
        logic [ADDR_W-1:0] rd_vs2;
        logic [ADDR_W-1:0] wr_addr;
    } rd_req_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        phit_t             data;
    } wr_req_t;

endpackage
